// File: testbench/eco_io_tests.mem
// kind size addr wdata expect
// kinds 0 idle(wdata cycles) 1 write 2 read 3 poll ctrl 4 irq 5 set sw 6 read sw
1 2 00000000 12345678 00000000
1 2 00000104 cafef00d 00000000
1 2 00000ffc a5a5c3c3 00000000
2 2 00000000 00000000 12345678
2 2 00000104 00000000 cafef00d
2 2 00000ffc 00000000 a5a5c3c3
1 2 00000200 11223344 00000000
1 0 00000201 123456ab 00000000
1 1 00000202 9876beef 00000000
1 0 00000200 0000005a 00000000
2 2 00000200 00000000 5aabbeef
2 0 00000203 00000000 000000ef
2 0 00000200 00000000 0000005a
2 1 00000200 00000000 00005aab
2 1 00000202 00000000 0000beef
1 2 f0000004 00000014 00000000
1 2 f0001004 00000032 00000000
2 2 f0000004 00000000 00000014
2 2 f0001004 00000000 00000032
3 2 f0000000 00000000 00000002
4 0 00000000 00000000 00000000
1 2 f0000000 00000001 00000000
2 2 f0000000 00000000 00000001
3 2 f0000000 00000000 00000003
4 0 00000000 00000000 00000001
1 2 f0000000 00000000 00000000
4 0 00000000 00000000 00000000
3 2 f0001000 00000000 00000002
1 2 f0001000 00000001 00000000
3 2 f0001000 00000000 00000003
4 0 00000000 00000000 00000002
1 2 f0001000 00000000 00000000
4 0 00000000 00000000 00000000
5 0 00000000 00000000 00000000
0 0 00000000 00000003 00000000
6 2 f1000000 00000000 00000000
1 2 f1000004 000000a5 00000000
2 2 f1000004 00000000 000000a5
2 2 80000000 00000000 00000000
1 2 80000000 deadbeef 00000000
2 2 00000000 00000000 12345678

// File: filelist.f
+incdir+common
common/eco_pkg.sv
common/eco_bus_if.sv
design/busctrl.sv
design/ram.sv
tmr/tmr.sv
design/bio.sv
design/eco_io.sv
testbench/eco_io_tb.sv

// File: Bender.yml
package:
  name: eco_io

export_include_dirs:
  - common

sources:
  - common/eco_pkg.sv
  - common/eco_bus_if.sv
  - design/busctrl.sv
  - design/ram.sv
  - tmr/tmr.sv
  - design/bio.sv
  - design/eco_io.sv
  - target: test
    files:
      - testbench/eco_io_tb.sv

// File: testbench/eco_io_tb.sv
// ECO I/O testbench
// file-driven bus transfers against RAM, timers and board I/O
`timescale 1ns/1ps
`default_nettype none
`include "eco_settings.svh"

module eco_io_tb;
  import eco_pkg::*;

  localparam int MAX_LINES = 64;

  // test line kinds
  localparam int K_IDLE    = 0;
  localparam int K_WRITE   = 1;
  localparam int K_READ    = 2;
  localparam int K_POLL    = 3;
  localparam int K_IRQ     = 4;
  localparam int K_SW_SET  = 5;
  localparam int K_SW_READ = 6;

  logic       clk;
  logic       rst_n;
  logic       bus_en;
  logic       bus_wr;
  bus_size_t  bus_size;
  word_t      bus_addr;
  word_t      bus_wdata;
  word_t      bus_rdata;
  logic       bus_wt;
  logic [3:0] sw_n;
  logic [7:0] led;
  logic [1:0] tmr_irq;

  word_t tests [MAX_LINES*5];
  // expected RAM contents, by word index
  word_t model [int];
  int    errors  = 0;
  int    n_lines = 0;
  int    limit   = 0;
  int    seed    = 32'he24ce8b7;

  eco_io UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_en    (bus_en),
    .bus_wr    (bus_wr),
    .bus_size  (bus_size),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_wt    (bus_wt),
    .sw_n      (sw_n),
    .led       (led),
    .tmr_irq   (tmr_irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %08h got %08h", $time, name, exp, act);
    end
  endtask

  task automatic check_irq(input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t tmr_irq expected %02b got %02b", $time, exp, act);
    end
  endtask

  task automatic check_wt(input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t bus_wt expected %0b got %0b", $time, exp, act);
    end
  endtask

  // starts at a falling edge, returns at the falling edge after completion
  task automatic transfer(input logic wr, input bus_size_t size, input word_t addr,
                          input word_t wdata, output word_t rdata);
    logic done;
    logic exp_wt;
    // only a RAM read waits, and only in its first cycle
    exp_wt    = !wr && in_ram(addr);
    bus_en    = 1'b1;
    bus_wr    = wr;
    bus_size  = size;
    bus_addr  = addr;
    bus_wdata = wdata;
    done      = 1'b0;
    while (!done) begin
      #1;
      check_wt(exp_wt, bus_wt);
      done   = !bus_wt;
      rdata  = bus_rdata;
      exp_wt = 1'b0;
      @(negedge clk);
    end
    bus_en = 1'b0;
  endtask

  function automatic logic in_ram(input word_t addr);
    return (addr & `ECO_RAM_MASK) == `ECO_RAM_BASE;
  endfunction

  function automatic logic is_timer(input word_t addr);
    return (addr & `ECO_DEV_MASK) == `ECO_TMR0_BASE ||
           (addr & `ECO_DEV_MASK) == `ECO_TMR1_BASE;
  endfunction

  // big-endian lanes, byte offset 0 is bits 31:24
  function automatic word_t merge_lanes(input word_t old, input bus_size_t size,
                                        input logic [1:0] off, input word_t wdata);
    word_t w;
    w = old;
    case (size)
      SIZE_BYTE: w[31-8*off -: 8] = wdata[7:0];
      SIZE_HALF: w[31-16*off[1] -: 16] = wdata[15:0];
      default:   w = wdata;
    endcase
    return w;
  endfunction

  function automatic word_t extract_lanes(input word_t w, input bus_size_t size,
                                          input logic [1:0] off);
    case (size)
      SIZE_BYTE: return {24'b0, w[31-8*off -: 8]};
      SIZE_HALF: return {16'b0, w[31-16*off[1] -: 16]};
      default:   return w;
    endcase
  endfunction

  initial begin
    word_t       kind;
    word_t       addr;
    word_t       wdata;
    word_t       exp;
    word_t       rd;
    bus_size_t   size;
    int          idx;
    int          tries;
    int          max_len;
    logic [31:0] rnd;
    rst_n     = 1'b0;
    bus_en    = 1'b0;
    bus_wr    = 1'b0;
    bus_size  = SIZE_WORD;
    bus_addr  = '0;
    bus_wdata = '0;
    sw_n      = 4'hf;
    max_len   = 0;
    $readmemh("testbench/eco_io_tests.mem", tests);
    // longest divisor or idle count sets the run length
    while (n_lines < MAX_LINES && tests[5*n_lines] !== 'x) begin
      kind  = tests[5*n_lines];
      addr  = tests[5*n_lines+2];
      wdata = tests[5*n_lines+3];
      if (kind == K_IDLE || (kind == K_WRITE && is_timer(addr) && addr[3:2] == 2'd1)) begin
        if (int'(wdata) > max_len) max_len = int'(wdata);
      end
      n_lines++;
    end
    if (n_lines == 0) begin
      errors++;
      $display("error: no test lines were read from the tests file");
    end
    limit = n_lines * (max_len + 8) + 100;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < n_lines; i++) begin
      kind  = tests[5*i];
      size  = bus_size_t'(tests[5*i+1][1:0]);
      addr  = tests[5*i+2];
      wdata = tests[5*i+3];
      exp   = tests[5*i+4];
      idx   = int'(addr[`ECO_RAM_AW-1:2]);
      case (kind)
        K_IDLE: repeat (wdata) @(negedge clk);
        K_WRITE: begin
          transfer(1'b1, size, addr, wdata, rd);
          if (in_ram(addr)) begin
            model[idx] = merge_lanes(model.exists(idx) ? model[idx] : 'x, size,
                                     addr[1:0], wdata);
          end
          if (addr == `ECO_BIO_BASE + 4) begin
            check_word("led", {24'b0, wdata[7:0]}, {24'b0, led});
          end
        end
        K_READ: begin
          transfer(1'b0, size, addr, '0, rd);
          check_word("bus_rdata", exp, rd);
          if (in_ram(addr) && model.exists(idx)) begin
            check_word("ram model", extract_lanes(model[idx], size, addr[1:0]), rd);
          end
        end
        K_POLL: begin
          tries = 0;
          rd    = '0;
          while (!rd[1] && tries < 2*max_len + 8) begin
            transfer(1'b0, SIZE_WORD, addr, '0, rd);
            tries++;
          end
          if (!rd[1]) begin
            errors++;
            $display("error: timer at %08h never set its expiry flag", addr);
          end else begin
            check_word("tmr ctrl", exp, rd);
          end
        end
        K_IRQ: check_irq(exp[1:0], tmr_irq);
        K_SW_SET: begin
          rnd  = $random(seed);
          sw_n = rnd[3:0];
        end
        K_SW_READ: begin
          transfer(1'b0, SIZE_WORD, addr, '0, rd);
          check_word("switches", {28'b0, ~sw_n}, rd);
        end
        default: begin
          errors++;
          $display("error: unknown test kind %0h on line %0d", kind, i);
        end
      endcase
    end
    $display("errors: %0d in %0d test lines", errors, n_lines);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("error: run did not finish within %0d cycles, errors: %0d", limit, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/eco_io.sv
// ECO memory and I/O top level
// bus controller with RAM, two interval timers and board I/O
`timescale 1ns/1ps
`default_nettype none
`include "eco_settings.svh"

module eco_io (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               bus_en,
  input  logic               bus_wr,
  input  eco_pkg::bus_size_t bus_size,
  input  logic [31:0]        bus_addr,
  input  eco_pkg::word_t     bus_wdata,
  output eco_pkg::word_t     bus_rdata,
  output logic               bus_wt,
  input  logic [3:0]         sw_n,
  output logic [7:0]         led,
  output logic [1:0]         tmr_irq
);

  eco_bus_if #(.ADDR_W(`ECO_RAM_AW)) ram_bus ();
  eco_bus_if #(.ADDR_W(`ECO_DEV_AW)) tmr0_bus ();
  eco_bus_if #(.ADDR_W(`ECO_DEV_AW)) tmr1_bus ();
  eco_bus_if #(.ADDR_W(`ECO_DEV_AW)) bio_bus ();

  busctrl busctrl_0 (
    .clk       (clk),
    .bus_en    (bus_en),
    .bus_wr    (bus_wr),
    .bus_size  (bus_size),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_wt    (bus_wt),
    .ram       (ram_bus.master),
    .tmr0      (tmr0_bus.master),
    .tmr1      (tmr1_bus.master),
    .bio       (bio_bus.master)
  );

  ram ram_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (ram_bus.device)
  );

  tmr tmr_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tmr0_bus.device),
    .irq   (tmr_irq[0])
  );

  tmr tmr_1 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tmr1_bus.device),
    .irq   (tmr_irq[1])
  );

  bio bio_0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bio_bus.device),
    .sw_n  (sw_n),
    .led   (led)
  );

endmodule

`default_nettype wire

// File: design/bio.sv
// board I/O
// synchronized switch inputs and an LED output register
`timescale 1ns/1ps
`default_nettype none

module bio (
  input  logic       clk,
  input  logic       rst_n,
  eco_bus_if.device  bus,
  input  logic [3:0] sw_n,
  output logic [7:0] led
);

  logic [3:0] sw_meta;
  logic [3:0] sw_sync;
  logic       sel_led;

  // register 1 at offset 4
  assign sel_led = bus.addr[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sw_meta <= 4'hf;
      sw_sync <= 4'hf;
      led     <= '0;
    end else begin
      sw_meta <= sw_n;
      sw_sync <= sw_meta;
      if (bus.en && bus.wr && sel_led) begin
        led <= bus.wdata[7:0];
      end
    end
  end

  // switches read active high
  assign bus.rdata = sel_led ? {24'b0, led} : {28'b0, ~sw_sync};
  assign bus.wt    = 1'b0;

endmodule

`default_nettype wire

// File: tmr/tmr.sv
// interval timer
// counts down from a divisor, flags expiry and raises a maskable irq
`timescale 1ns/1ps
`default_nettype none
`include "eco_settings.svh"

module tmr (
  input  logic       clk,
  input  logic       rst_n,
  eco_bus_if.device  bus,
  output logic       irq
);
  import eco_pkg::*;

  logic [`ECO_TMR_W-1:0] div;
  logic [`ECO_TMR_W-1:0] cnt;
  logic                  ie;
  logic                  flag;
  logic                  wr_ctrl;
  logic                  wr_div;
  tmr_reg_t              sel;

  assign sel     = tmr_reg_t'(bus.addr[3:2]);
  assign wr_ctrl = bus.en & bus.wr & (sel == TMR_CTRL);
  assign wr_div  = bus.en & bus.wr & (sel == TMR_DIV);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ie   <= 1'b0;
      flag <= 1'b0;
      div  <= '0;
      cnt  <= '0;
    end else begin
      if (wr_ctrl) begin
        ie   <= bus.wdata[0];
        flag <= 1'b0;
      end
      if (wr_div) begin
        div <= bus.wdata[`ECO_TMR_W-1:0];
        cnt <= bus.wdata[`ECO_TMR_W-1:0];
      end else if (div != '0) begin
        // expire as the count would reach zero
        if (cnt <= 1) begin
          cnt  <= div;
          flag <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  assign irq = flag & ie;

  always_comb begin
    case (sel)
      TMR_CTRL: bus.rdata = {30'b0, flag, ie};
      TMR_DIV:  bus.rdata = word_t'(div);
      TMR_CNT:  bus.rdata = word_t'(cnt);
      default:  bus.rdata = '0;
    endcase
  end

  assign bus.wt = 1'b0;

  // masking through the control register silences irq at once
  a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_ctrl && !bus.wdata[0]) |=> !irq);

endmodule

`default_nettype wire

// File: design/ram.sv
// on-chip word RAM
// big-endian byte and halfword access, reads take one wait cycle
`timescale 1ns/1ps
`default_nettype none
`include "eco_settings.svh"

module ram (
  input logic        clk,
  input logic        rst_n,
  eco_bus_if.device  bus
);
  import eco_pkg::*;

  localparam int IDX_W = $clog2(`ECO_RAM_WORDS);

  word_t            mem [`ECO_RAM_WORDS];
  word_t            rd_q;
  word_t            wd;
  ram_state_t       state;
  logic [IDX_W-1:0] idx;
  logic [1:0]       off;
  logic [1:0]       lane;
  logic [3:0]       be;

  assign idx  = bus.addr[`ECO_RAM_AW-1:2];
  assign off  = bus.addr[1:0];
  assign lane = 2'd3 - off;

  // byte offset 0 is the most significant lane
  always_comb begin
    case (bus.size)
      SIZE_BYTE: begin
        be = 4'b1000 >> off;
        wd = {4{bus.wdata[7:0]}};
      end
      SIZE_HALF: begin
        be = off[1] ? 4'b0011 : 4'b1100;
        wd = {2{bus.wdata[15:0]}};
      end
      default: begin
        be = 4'b1111;
        wd = bus.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.en && bus.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[idx][8*i +: 8] <= wd[8*i +: 8];
        end
      end
    end
    rd_q <= mem[idx];
  end

  // second cycle of a read returns the registered word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RAM_IDLE;
    end else if (state == RAM_IDLE && bus.en && !bus.wr) begin
      state <= RAM_READ;
    end else begin
      state <= RAM_IDLE;
    end
  end

  assign bus.wt = bus.en & ~bus.wr & (state == RAM_IDLE);

  always_comb begin
    case (bus.size)
      SIZE_BYTE: bus.rdata = {24'b0, rd_q[{lane, 3'b000} +: 8]};
      SIZE_HALF: bus.rdata = {16'b0, off[1] ? rd_q[15:0] : rd_q[31:16]};
      default:   bus.rdata = rd_q;
    endcase
  end

  a_wt_single: assert property (@(posedge clk) disable iff (!rst_n)
    bus.wt |=> !bus.wt);

endmodule

`default_nettype wire

// File: design/busctrl.sv
// bus controller
// decodes one master transfer to RAM, timers or board I/O
`timescale 1ns/1ps
`default_nettype none
`include "eco_settings.svh"

module busctrl (
  input  logic               clk,
  input  logic               bus_en,
  input  logic               bus_wr,
  input  eco_pkg::bus_size_t bus_size,
  input  logic [31:0]        bus_addr,
  input  eco_pkg::word_t     bus_wdata,
  output eco_pkg::word_t     bus_rdata,
  output logic               bus_wt,
  eco_bus_if.master          ram,
  eco_bus_if.master          tmr0,
  eco_bus_if.master          tmr1,
  eco_bus_if.master          bio
);

  logic ram_hit;
  logic tmr0_hit;
  logic tmr1_hit;
  logic bio_hit;

  assign ram_hit  = (bus_addr & `ECO_RAM_MASK) == `ECO_RAM_BASE;
  assign tmr0_hit = (bus_addr & `ECO_DEV_MASK) == `ECO_TMR0_BASE;
  assign tmr1_hit = (bus_addr & `ECO_DEV_MASK) == `ECO_TMR1_BASE;
  assign bio_hit  = (bus_addr & `ECO_DEV_MASK) == `ECO_BIO_BASE;

  // request fan-out with device-local addresses
  assign ram.en    = bus_en & ram_hit;
  assign ram.wr    = bus_wr;
  assign ram.size  = bus_size;
  assign ram.addr  = bus_addr[`ECO_RAM_AW-1:0];
  assign ram.wdata = bus_wdata;

  assign tmr0.en    = bus_en & tmr0_hit;
  assign tmr0.wr    = bus_wr;
  assign tmr0.size  = bus_size;
  assign tmr0.addr  = bus_addr[`ECO_DEV_AW-1:0];
  assign tmr0.wdata = bus_wdata;

  assign tmr1.en    = bus_en & tmr1_hit;
  assign tmr1.wr    = bus_wr;
  assign tmr1.size  = bus_size;
  assign tmr1.addr  = bus_addr[`ECO_DEV_AW-1:0];
  assign tmr1.wdata = bus_wdata;

  assign bio.en    = bus_en & bio_hit;
  assign bio.wr    = bus_wr;
  assign bio.size  = bus_size;
  assign bio.addr  = bus_addr[`ECO_DEV_AW-1:0];
  assign bio.wdata = bus_wdata;

  // reply mux, unmapped space reads zero without wait
  always_comb begin
    bus_rdata = '0;
    bus_wt    = 1'b0;
    if (ram_hit) begin
      bus_rdata = ram.rdata;
      bus_wt    = ram.wt;
    end else if (tmr0_hit) begin
      bus_rdata = tmr0.rdata;
      bus_wt    = tmr0.wt;
    end else if (tmr1_hit) begin
      bus_rdata = tmr1.rdata;
      bus_wt    = tmr1.wt;
    end else if (bio_hit) begin
      bus_rdata = bio.rdata;
      bus_wt    = bio.wt;
    end
  end

  a_one_device: assert property (@(posedge clk)
    $onehot0({ram.en, tmr0.en, tmr1.en, bio.en}));

endmodule

`default_nettype wire

// File: common/eco_bus_if.sv
// ECO bus slave connection
// one decoded request from the controller and the device's reply
`timescale 1ns/1ps
`default_nettype none

interface eco_bus_if #(
  parameter int ADDR_W = 32
);
  import eco_pkg::*;

  logic              en;
  logic              wr;
  bus_size_t         size;
  logic [ADDR_W-1:0] addr;
  word_t             wdata;
  word_t             rdata;
  logic              wt;

  modport master (
    output en, wr, size, addr, wdata,
    input  rdata, wt
  );

  modport device (
    input  en, wr, size, addr, wdata,
    output rdata, wt
  );

endinterface

`default_nettype wire

// File: common/eco_pkg.sv
// ECO bus types
// data word, transfer size and device register encodings
`default_nettype none

package eco_pkg;

  typedef logic [31:0] word_t;

  // ECO32 transfer size encoding
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } bus_size_t;

  // timer register, from address bits 3:2
  typedef enum logic [1:0] {
    TMR_CTRL = 2'd0,
    TMR_DIV  = 2'd1,
    TMR_CNT  = 2'd2
  } tmr_reg_t;

  typedef enum logic {
    RAM_IDLE = 1'b0,
    RAM_READ = 1'b1
  } ram_state_t;

endpackage

`default_nettype wire

// File: common/eco_settings.svh
// ECO I/O subsystem settings
// address map, RAM depth and timer width
`ifndef ECO_SETTINGS_SVH
`define ECO_SETTINGS_SVH

// RAM depth in 32-bit words
`define ECO_RAM_WORDS 1024

// byte address width seen by the RAM
`define ECO_RAM_AW ($clog2(`ECO_RAM_WORDS) + 2)

// local address width of the register devices
`define ECO_DEV_AW 4

// device base addresses
`define ECO_RAM_BASE  32'h0000_0000
`define ECO_TMR0_BASE 32'hF000_0000
`define ECO_TMR1_BASE 32'hF000_1000
`define ECO_BIO_BASE  32'hF100_0000

// high address bits compared against a base
`define ECO_RAM_MASK 32'hFFFF_F000
`define ECO_DEV_MASK 32'hFFFF_FFF0

// timer counter width
`define ECO_TMR_W 32

`endif
